/* hdl/mipsPkg.sv */
package mipsPkg;

    localparam int dataWidth     = 32;
    localparam int wordAddrWidth = 30;
    localparam int regAddrWidth  = 5;

    typedef logic [5:0] opcodeT;
    typedef logic [5:0] functT;

    localparam opcodeT opRtype = 6'h00;
    localparam opcodeT opAddi  = 6'h08;
    localparam opcodeT opLw    = 6'h23;
    localparam opcodeT opSw    = 6'h2b;
    localparam opcodeT opBeq   = 6'h04;
    localparam opcodeT opJ     = 6'h02;

    localparam functT functAdd = 6'h20;
    localparam functT functSub = 6'h22;
    localparam functT functAnd = 6'h24;
    localparam functT functOr  = 6'h25;
    localparam functT functSlt = 6'h2a;

    // ALU class from the main decoder
    typedef enum logic [1:0] {
        aluOpAdd,
        aluOpSub,
        aluOpRtype
    } aluOpT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluCtrlT;

    // All zero is a bubble
    typedef struct packed {
        logic  regDst;
        logic  aluSrc;
        aluOpT aluOp;
        logic  branch;
        logic  jump;
        logic  memRead;
        logic  memWrite;
        logic  memToReg;
        logic  regWrite;
    } ctrlT;

    typedef struct packed {
        logic [dataWidth-1:0] pcPlus4;
        logic [dataWidth-1:0] instr;
    } ifIdT;

    typedef struct packed {
        ctrlT                    ctrl;
        logic [dataWidth-1:0]    pcPlus4;
        logic [dataWidth-1:0]    rsData;
        logic [dataWidth-1:0]    rtData;
        logic [dataWidth-1:0]    imm;
        logic [regAddrWidth-1:0] rs;
        logic [regAddrWidth-1:0] rt;
        logic [regAddrWidth-1:0] rd;
    } idExT;

    typedef struct packed {
        logic                    branch;
        logic                    memRead;
        logic                    memWrite;
        logic                    memToReg;
        logic                    regWrite;
        logic                    zero;
        logic [dataWidth-1:0]    branchTarget;
        logic [dataWidth-1:0]    aluResult;
        logic [dataWidth-1:0]    storeData;
        logic [regAddrWidth-1:0] destReg;
    } exMemT;

    typedef struct packed {
        logic                    memToReg;
        logic                    regWrite;
        logic [dataWidth-1:0]    loadData;
        logic [dataWidth-1:0]    aluResult;
        logic [regAddrWidth-1:0] destReg;
    } memWbT;

    typedef enum logic [1:0] {
        fwdNone,
        fwdFromMem,
        fwdFromWb
    } fwdSelT;

endpackage

/* hdl/pipeStage.sv */
module pipeStage #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    hold,
    input  logic    flush,
    input  payloadT d,
    output payloadT q
);

    // Hold wins over flush so a stalled cache sees stable outputs
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q <= '0;
        end else if (hold) begin
            q <= q;
        end else if (flush) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

/* hdl/fetchUnit.sv */
module fetchUnit (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               hold,
    input  logic                               branchTaken,
    input  logic [mipsPkg::dataWidth-1:0]      branchTarget,
    input  logic                               jumpTaken,
    input  logic [mipsPkg::dataWidth-1:0]      jumpTarget,
    output logic [mipsPkg::wordAddrWidth-1:0]  iCacheAddr,
    output logic [mipsPkg::dataWidth-1:0]      pcPlus4
);

    logic [mipsPkg::dataWidth-1:0] pc;
    logic [mipsPkg::dataWidth-1:0] nextPc;

    assign pcPlus4 = pc + 32'd4;

    // Branch in MEM is older than a jump in ID
    always_comb begin
        if (branchTaken) begin
            nextPc = branchTarget;
        end else if (jumpTaken) begin
            nextPc = jumpTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!hold) begin
            pc <= nextPc;
        end
    end

    assign iCacheAddr = pc[31:2];

endmodule

/* hdl/decodeUnit.sv */
module decodeUnit (
    input  logic                              clk,
    input  logic                              rst_n,
    input  mipsPkg::ifIdT                     ifId,
    input  logic                              bubble,
    input  logic [mipsPkg::regAddrWidth-1:0]  wbDest,
    input  logic [mipsPkg::dataWidth-1:0]     wbData,
    input  logic                              wbWrite,
    output mipsPkg::idExT                     idEx,
    output logic                              jumpTaken,
    output logic [mipsPkg::dataWidth-1:0]     jumpTarget
);

    import mipsPkg::*;

    logic [dataWidth-1:0]    regs [32];
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    opcodeT                  opcode;
    ctrlT                    decoded;
    ctrlT                    ctrl;

    assign opcode = ifId.instr[31:26];
    assign rs     = ifId.instr[25:21];
    assign rt     = ifId.instr[20:16];

    always_comb begin
        decoded = '0;
        case (opcode)
            opRtype: begin
                decoded.regDst   = 1'b1;
                decoded.aluOp    = aluOpRtype;
                decoded.regWrite = 1'b1;
            end
            opAddi: begin
                decoded.aluSrc   = 1'b1;
                decoded.regWrite = 1'b1;
            end
            opLw: begin
                decoded.aluSrc   = 1'b1;
                decoded.memRead  = 1'b1;
                decoded.memToReg = 1'b1;
                decoded.regWrite = 1'b1;
            end
            opSw: begin
                decoded.aluSrc   = 1'b1;
                decoded.memWrite = 1'b1;
            end
            opBeq: begin
                decoded.branch = 1'b1;
                decoded.aluOp  = aluOpSub;
            end
            opJ:     decoded.jump = 1'b1;
            default: decoded = '0;
        endcase
    end

    // Load-use bubble
    assign ctrl = bubble ? '0 : decoded;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wbWrite && wbDest != '0) begin
            regs[wbDest] <= wbData;
        end
    end

    // Write-first bypass from writeback
    assign idEx.rsData = (rs == '0) ? '0 :
                         (wbWrite && wbDest == rs) ? wbData : regs[rs];
    assign idEx.rtData = (rt == '0) ? '0 :
                         (wbWrite && wbDest == rt) ? wbData : regs[rt];

    assign idEx.ctrl    = ctrl;
    assign idEx.pcPlus4 = ifId.pcPlus4;
    assign idEx.imm     = {{16{ifId.instr[15]}}, ifId.instr[15:0]};
    assign idEx.rs      = rs;
    assign idEx.rt      = rt;
    assign idEx.rd      = ifId.instr[15:11];

    assign jumpTaken  = ctrl.jump;
    assign jumpTarget = {ifId.pcPlus4[31:28], ifId.instr[25:0], 2'b00};

endmodule

/* hdl/executeUnit.sv */
module executeUnit (
    input  mipsPkg::idExT                  idEx,
    input  mipsPkg::fwdSelT                fwdA,
    input  mipsPkg::fwdSelT                fwdB,
    input  logic [mipsPkg::dataWidth-1:0]  memResult,
    input  logic [mipsPkg::dataWidth-1:0]  wbData,
    output mipsPkg::exMemT                 exMem
);

    import mipsPkg::*;

    aluCtrlT              aluCtrl;
    functT                funct;
    logic [dataWidth-1:0] opA;
    logic [dataWidth-1:0] rtValue;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] result;

    assign funct = idEx.imm[5:0];

    always_comb begin
        case (idEx.ctrl.aluOp)
            aluOpSub: aluCtrl = aluSub;
            aluOpRtype: begin
                case (funct)
                    functSub: aluCtrl = aluSub;
                    functAnd: aluCtrl = aluAnd;
                    functOr:  aluCtrl = aluOr;
                    functSlt: aluCtrl = aluSlt;
                    functAdd: aluCtrl = aluAdd;
                    default:  aluCtrl = aluAdd;
                endcase
            end
            default: aluCtrl = aluAdd;
        endcase
    end

    // MEM holds the newer value, so it is checked first in hazardUnit
    assign opA = (fwdA == fwdFromMem) ? memResult :
                 (fwdA == fwdFromWb)  ? wbData : idEx.rsData;
    assign rtValue = (fwdB == fwdFromMem) ? memResult :
                     (fwdB == fwdFromWb)  ? wbData : idEx.rtData;
    assign opB = idEx.ctrl.aluSrc ? idEx.imm : rtValue;

    always_comb begin
        case (aluCtrl)
            aluSub:  result = opA - opB;
            aluAnd:  result = opA & opB;
            aluOr:   result = opA | opB;
            aluSlt:  result = {31'd0, $signed(opA) < $signed(opB)};
            default: result = opA + opB;
        endcase
    end

    assign exMem.branch       = idEx.ctrl.branch;
    assign exMem.memRead      = idEx.ctrl.memRead;
    assign exMem.memWrite     = idEx.ctrl.memWrite;
    assign exMem.memToReg     = idEx.ctrl.memToReg;
    assign exMem.regWrite     = idEx.ctrl.regWrite;
    assign exMem.zero         = (result == '0);
    assign exMem.branchTarget = idEx.pcPlus4 + {idEx.imm[29:0], 2'b00};
    assign exMem.aluResult    = result;
    assign exMem.storeData    = rtValue;
    assign exMem.destReg      = idEx.ctrl.regDst ? idEx.rd : idEx.rt;

endmodule

/* hdl/hazardUnit.sv */
module hazardUnit (
    input  mipsPkg::idExT    idEx,
    input  mipsPkg::ifIdT    ifId,
    input  mipsPkg::exMemT   exMem,
    input  mipsPkg::memWbT   memWb,
    output logic             loadUse,
    output mipsPkg::fwdSelT  fwdA,
    output mipsPkg::fwdSelT  fwdB
);

    import mipsPkg::*;

    logic [regAddrWidth-1:0] idRs;
    logic [regAddrWidth-1:0] idRt;
    logic                    memWrites;
    logic                    wbWrites;

    assign idRs = ifId.instr[25:21];
    assign idRt = ifId.instr[20:16];

    // Load in EX whose result the next instruction needs
    assign loadUse = idEx.ctrl.memRead && (idEx.rt == idRs || idEx.rt == idRt);

    // Register 0 never forwards
    assign memWrites = exMem.regWrite && exMem.destReg != '0;
    assign wbWrites  = memWb.regWrite && memWb.destReg != '0;

    always_comb begin
        fwdA = fwdNone;
        if (memWrites && exMem.destReg == idEx.rs) begin
            fwdA = fwdFromMem;
        end else if (wbWrites && memWb.destReg == idEx.rs) begin
            fwdA = fwdFromWb;
        end
    end

    always_comb begin
        fwdB = fwdNone;
        if (memWrites && exMem.destReg == idEx.rt) begin
            fwdB = fwdFromMem;
        end else if (wbWrites && memWb.destReg == idEx.rt) begin
            fwdB = fwdFromWb;
        end
    end

endmodule

/* hdl/mipsPipeline.sv */
module mipsPipeline (
    input  logic                               clk,
    input  logic                               rst_n,
    output logic [mipsPkg::wordAddrWidth-1:0]  iCacheAddr,
    input  logic [mipsPkg::dataWidth-1:0]      iCacheRdata,
    input  logic                               iCacheStall,
    output logic                               dCacheRen,
    output logic                               dCacheWen,
    output logic [mipsPkg::wordAddrWidth-1:0]  dCacheAddr,
    output logic [mipsPkg::dataWidth-1:0]      dCacheWdata,
    input  logic [mipsPkg::dataWidth-1:0]      dCacheRdata,
    input  logic                               dCacheStall
);

    import mipsPkg::*;

    ifIdT                 ifIdD, ifIdQ;
    idExT                 idExD, idExQ;
    exMemT                exMemD, exMemQ;
    memWbT                memWbD, memWbQ;
    fwdSelT               fwdA, fwdB;
    logic                 globalHold;
    logic                 loadUse;
    logic                 stall;
    logic                 branchTaken;
    logic                 jumpTaken;
    logic [dataWidth-1:0] jumpTarget;
    logic [dataWidth-1:0] pcPlus4;
    logic [dataWidth-1:0] wbData;

    assign globalHold  = iCacheStall | dCacheStall;
    assign branchTaken = exMemQ.branch & exMemQ.zero;
    // A taken branch squashes the stalled load, so it must not block the redirect
    assign stall = loadUse & ~branchTaken;

    fetchUnit fetchUnit_inst (
        .clk(clk), .rst_n(rst_n), .hold(globalHold | stall),
        .branchTaken(branchTaken), .branchTarget(exMemQ.branchTarget),
        .jumpTaken(jumpTaken), .jumpTarget(jumpTarget),
        .iCacheAddr(iCacheAddr), .pcPlus4(pcPlus4)
    );

    assign ifIdD = '{pcPlus4: pcPlus4, instr: iCacheRdata};

    pipeStage #(.payloadT(ifIdT)) ifIdStage (
        .clk(clk), .rst_n(rst_n), .hold(globalHold | stall),
        .flush(jumpTaken | branchTaken), .d(ifIdD), .q(ifIdQ)
    );

    decodeUnit decodeUnit_inst (
        .clk(clk), .rst_n(rst_n), .ifId(ifIdQ), .bubble(loadUse),
        .wbDest(memWbQ.destReg), .wbData(wbData), .wbWrite(memWbQ.regWrite),
        .idEx(idExD), .jumpTaken(jumpTaken), .jumpTarget(jumpTarget)
    );

    pipeStage #(.payloadT(idExT)) idExStage (
        .clk(clk), .rst_n(rst_n), .hold(globalHold),
        .flush(branchTaken), .d(idExD), .q(idExQ)
    );

    executeUnit executeUnit_inst (
        .idEx(idExQ), .fwdA(fwdA), .fwdB(fwdB),
        .memResult(exMemQ.aluResult), .wbData(wbData), .exMem(exMemD)
    );

    pipeStage #(.payloadT(exMemT)) exMemStage (
        .clk(clk), .rst_n(rst_n), .hold(globalHold),
        .flush(branchTaken), .d(exMemD), .q(exMemQ)
    );

    hazardUnit hazardUnit_inst (
        .idEx(idExQ), .ifId(ifIdQ), .exMem(exMemQ), .memWb(memWbQ),
        .loadUse(loadUse), .fwdA(fwdA), .fwdB(fwdB)
    );

    // Data cache driven straight from EX/MEM
    assign dCacheRen   = exMemQ.memRead;
    assign dCacheWen   = exMemQ.memWrite;
    assign dCacheAddr  = exMemQ.aluResult[31:2];
    assign dCacheWdata = exMemQ.storeData;

    assign memWbD.memToReg  = exMemQ.memToReg;
    assign memWbD.regWrite  = exMemQ.regWrite;
    assign memWbD.loadData  = dCacheRdata;
    assign memWbD.aluResult = exMemQ.aluResult;
    assign memWbD.destReg   = exMemQ.destReg;

    pipeStage #(.payloadT(memWbT)) memWbStage (
        .clk(clk), .rst_n(rst_n), .hold(globalHold),
        .flush(1'b0), .d(memWbD), .q(memWbQ)
    );

    assign wbData = memWbQ.memToReg ? memWbQ.loadData : memWbQ.aluResult;

endmodule

/* testbench/mipsPipeline_assert.sv */
module mipsPipeline_assert (
    input logic                               clk,
    input logic                               rst_n,
    input logic [mipsPkg::wordAddrWidth-1:0]  iCacheAddr,
    input logic                               iCacheStall,
    input logic                               dCacheRen,
    input logic                               dCacheWen,
    input logic [mipsPkg::wordAddrWidth-1:0]  dCacheAddr,
    input logic [mipsPkg::dataWidth-1:0]      dCacheWdata,
    input logic                               dCacheStall
);

    // Read by the testbench at the end of the run
    int failCount = 0;

    noReadWithWrite: assert property (@(posedge clk) disable iff (!rst_n)
        !(dCacheRen && dCacheWen))
        else begin
            failCount++;
            $error("dCacheRen and dCacheWen are high together");
        end

    // Held pipeline keeps the data cache request steady
    dCacheStable: assert property (@(posedge clk) disable iff (!rst_n)
        dCacheStall |=> ($stable(dCacheAddr) && $stable(dCacheWdata)))
        else begin
            failCount++;
            $error("dCacheAddr or dCacheWdata changed during a data cache stall");
        end

    iCacheStable: assert property (@(posedge clk) disable iff (!rst_n)
        iCacheStall |=> $stable(iCacheAddr))
        else begin
            failCount++;
            $error("iCacheAddr changed during an instruction cache stall");
        end

endmodule

bind mipsPipeline mipsPipeline_assert mipsPipeline_assert_inst (.*);

/* testbench/mipsPipelineTb.sv */
module mipsPipelineTb;

    import mipsPkg::*;

    localparam int progLen      = 31;
    localparam int numStores    = 11;
    localparam int memWords     = 64;
    localparam int storeTimeout = 400;

    typedef struct packed {
        logic [wordAddrWidth-1:0] addr;
        logic [dataWidth-1:0]     data;
    } storeT;

    logic                     clk;
    logic                     rst_n;
    logic [wordAddrWidth-1:0] iCacheAddr;
    logic [dataWidth-1:0]     iCacheRdata;
    logic                     iCacheStall;
    logic                     dCacheRen;
    logic                     dCacheWen;
    logic [wordAddrWidth-1:0] dCacheAddr;
    logic [dataWidth-1:0]     dCacheWdata;
    logic [dataWidth-1:0]     dCacheRdata;
    logic                     dCacheStall;

    logic [dataWidth-1:0] imem [memWords];
    logic [dataWidth-1:0] dmem [memWords];
    logic [dataWidth-1:0] progTable [progLen];
    storeT                expStores [numStores];
    logic                 stallsOn;
    logic [31:0]          rngState;

    mipsPipeline mipsPipeline_inst (
        .clk(clk), .rst_n(rst_n),
        .iCacheAddr(iCacheAddr), .iCacheRdata(iCacheRdata), .iCacheStall(iCacheStall),
        .dCacheRen(dCacheRen), .dCacheWen(dCacheWen), .dCacheAddr(dCacheAddr),
        .dCacheWdata(dCacheWdata), .dCacheRdata(dCacheRdata), .dCacheStall(dCacheStall)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] encodeR(input functT funct, input logic [4:0] rd,
                                            input logic [4:0] rs, input logic [4:0] rt);
        return {opRtype, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encodeI(input opcodeT op, input logic [4:0] rt,
                                            input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encodeJ(input int target);
        return {opJ, 26'(target)};
    endfunction

    // Every word of the data memory differs
    function automatic logic [31:0] fillWord(input int idx);
        return 32'hd15c0000 + idx * 32'h101;
    endfunction

    // Cache models, read data only for a real load
    assign iCacheRdata = iCacheStall ? 'x : imem[iCacheAddr[5:0]];
    assign dCacheRdata = (dCacheStall || !dCacheRen) ? 'x : dmem[dCacheAddr[5:0]];

    always @(posedge clk) begin
        if (dCacheWen && !dCacheStall) begin
            dmem[dCacheAddr[5:0]] <= dCacheWdata;
        end
    end

    // Stall levels change a little after each rising edge
    always @(posedge clk) begin
        #2;
        if (stallsOn) begin
            rngState = xorshift32(rngState);
            iCacheStall = (rngState[1:0] == 2'b00);
            dCacheStall = (rngState[9:8] == 2'b00);
        end else begin
            iCacheStall = 1'b0;
            dCacheStall = 1'b0;
        end
    end

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            abortRun($sformatf("Error: %s is %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic buildTables();
        // Forwarding from MEM and WB, r1 = 5, r2 = -3
        progTable[0]  = encodeI(opAddi, 5'd1, 5'd0, 16'd5);
        progTable[1]  = encodeI(opAddi, 5'd2, 5'd0, 16'hfffd);
        progTable[2]  = encodeR(functAdd, 5'd3, 5'd1, 5'd2);
        progTable[3]  = encodeR(functSub, 5'd4, 5'd1, 5'd3);
        progTable[4]  = encodeI(opSw, 5'd3, 5'd0, 16'h0040);
        progTable[5]  = encodeI(opSw, 5'd4, 5'd0, 16'h0044);
        progTable[6]  = encodeR(functAnd, 5'd5, 5'd3, 5'd4);
        progTable[7]  = encodeR(functOr, 5'd6, 5'd5, 5'd1);
        progTable[8]  = encodeR(functSlt, 5'd7, 5'd2, 5'd1);
        progTable[9]  = encodeR(functSlt, 5'd8, 5'd1, 5'd2);
        progTable[10] = encodeI(opSw, 5'd5, 5'd0, 16'h0048);
        progTable[11] = encodeI(opSw, 5'd6, 5'd0, 16'h004c);
        progTable[12] = encodeI(opSw, 5'd7, 5'd0, 16'h0050);
        progTable[13] = encodeI(opSw, 5'd8, 5'd0, 16'h0054);
        // Load-use pairs
        progTable[14] = encodeI(opLw, 5'd9, 5'd0, 16'h0044);
        progTable[15] = encodeR(functAdd, 5'd10, 5'd9, 5'd1);
        progTable[16] = encodeI(opSw, 5'd10, 5'd0, 16'h0058);
        progTable[17] = encodeI(opLw, 5'd11, 5'd0, 16'h0080);
        progTable[18] = encodeI(opAddi, 5'd12, 5'd11, 16'd16);
        progTable[19] = encodeI(opSw, 5'd12, 5'd0, 16'h005c);
        // Taken beq over three stores, then a not-taken one
        progTable[20] = encodeI(opBeq, 5'd1, 5'd1, 16'd3);
        progTable[21] = encodeI(opSw, 5'd1, 5'd0, 16'h0060);
        progTable[22] = encodeI(opSw, 5'd2, 5'd0, 16'h0064);
        progTable[23] = encodeI(opSw, 5'd3, 5'd0, 16'h0068);
        progTable[24] = encodeI(opSw, 5'd1, 5'd0, 16'h006c);
        progTable[25] = encodeI(opBeq, 5'd2, 5'd1, 16'd1);
        progTable[26] = encodeI(opSw, 5'd2, 5'd0, 16'h0070);
        progTable[27] = encodeJ(29);
        progTable[28] = encodeI(opSw, 5'd3, 5'd0, 16'h0074);
        progTable[29] = encodeI(opSw, 5'd4, 5'd0, 16'h0078);
        progTable[30] = encodeJ(30);

        expStores[0]  = '{addr: 30'd16, data: 32'h0000_0002};
        expStores[1]  = '{addr: 30'd17, data: 32'h0000_0003};
        expStores[2]  = '{addr: 30'd18, data: 32'h0000_0002};
        expStores[3]  = '{addr: 30'd19, data: 32'h0000_0007};
        expStores[4]  = '{addr: 30'd20, data: 32'h0000_0001};
        expStores[5]  = '{addr: 30'd21, data: 32'h0000_0000};
        expStores[6]  = '{addr: 30'd22, data: 32'h0000_0008};
        expStores[7]  = '{addr: 30'd23, data: 32'hd15c_2030};
        expStores[8]  = '{addr: 30'd27, data: 32'h0000_0005};
        expStores[9]  = '{addr: 30'd28, data: 32'hffff_fffd};
        expStores[10] = '{addr: 30'd30, data: 32'h0000_0003};
    endtask

    task automatic loadMemories();
        for (int i = 0; i < memWords; i++) begin
            imem[i] = (i < progLen) ? progTable[i] : encodeJ(i);
            dmem[i] = fillWord(i);
        end
    endtask

    // Called a small delay after a rising edge
    task automatic applyReset(input logic withStalls);
        rst_n = 1'b0;
        repeat (15) @(posedge clk);
        @(negedge clk);
        loadMemories();
        checkValue("dCacheRen", 32'(dCacheRen), 32'd0);
        checkValue("dCacheWen", 32'(dCacheWen), 32'd0);
        checkValue("iCacheAddr", 32'(iCacheAddr), 32'd0);
        stallsOn = withStalls;
        @(posedge clk);
        #2;
        rst_n = 1'b1;
    endtask

    // A store completes when the whole pipeline advances past MEM
    task automatic runStores();
        int waited;
        for (int n = 0; n < numStores; n++) begin
            waited = 0;
            @(negedge clk);
            while (!(dCacheWen && !dCacheStall && !iCacheStall)) begin
                if (waited == storeTimeout) begin
                    abortRun($sformatf("No store arrived for entry %0d within %0d cycles",
                                       n, storeTimeout));
                end
                waited++;
                @(negedge clk);
            end
            checkValue("dCacheAddr", 32'(dCacheAddr), 32'(expStores[n].addr));
            checkValue("dCacheWdata", dCacheWdata, expStores[n].data);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        iCacheStall = 1'b0;
        dCacheStall = 1'b0;
        stallsOn    = 1'b0;
        rngState    = 32'hac98598b;
        buildTables();
        // Second pass repeats the program under random cache stalls
        for (int pass = 0; pass < 2; pass++) begin
            stallsOn = 1'b0;
            if (pass > 0) begin
                @(posedge clk);
                #2;
            end
            applyReset(pass == 1);
            runStores();
        end
        if (mipsPipeline_inst.mipsPipeline_assert_inst.failCount != 0) begin
            abortRun("An assertion on the cache ports failed during the run");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

/* mipsPipeline.f */
hdl/mipsPkg.sv
hdl/pipeStage.sv
hdl/fetchUnit.sv
hdl/decodeUnit.sv
hdl/executeUnit.sv
hdl/hazardUnit.sv
hdl/mipsPipeline.sv
testbench/mipsPipeline_assert.sv
testbench/mipsPipelineTb.sv

/* Bender.yml */
package:
  name: mips_pipeline

sources:
  - hdl/mipsPkg.sv
  - hdl/pipeStage.sv
  - hdl/fetchUnit.sv
  - hdl/decodeUnit.sv
  - hdl/executeUnit.sv
  - hdl/hazardUnit.sv
  - hdl/mipsPipeline.sv
  - target: test
    files:
      - testbench/mipsPipeline_assert.sv
      - testbench/mipsPipelineTb.sv
